//--- logic/knightPkg.sv
`default_nettype none

package knightPkg;

  ////////////////////////////////////////
  // Timing constants
  ////////////////////////////////////////

  // Clock cycles per UART bit
  localparam int BAUD_DIV = 16;
  localparam int BAUD_W = $clog2(BAUD_DIV);

  // Gyro calibration length in clock cycles
  localparam int CAL_CYCLES = 200;
  localparam int CAL_W = $clog2(CAL_CYCLES);

  // Travel time for one board square
  localparam int SQUARE_CYCLES = 64;
  localparam int SQ_W = $clog2(SQUARE_CYCLES);

  // Highest legal coordinate on the 5x5 board
  localparam int BOARD_MAX = 4;

  ////////////////////////////////////////
  // Response bytes
  ////////////////////////////////////////

  localparam logic [7:0] ACK = 8'hA5;
  localparam logic [7:0] NAK = 8'h5A;

  ////////////////////////////////////////
  // Command fields
  ////////////////////////////////////////

  // Opcode in command bits 15 to 12
  typedef enum logic [3:0] {
    CAL_GYRO = 4'h2,
    MOVE     = 4'h4
  } opcode_e;

  // Heading in command bits 11 to 4
  // North is +y and east is +x
  typedef enum logic [7:0] {
    NORTH = 8'h00,
    WEST  = 8'h3F,
    SOUTH = 8'h7F,
    EAST  = 8'hBF
  } heading_e;

  // Full 16-bit host command, high byte first on the wire
  typedef struct packed {
    opcode_e    opcode;
    heading_e   heading;
    logic [3:0] squares;
  } cmd_t;

  // Board square of the robot
  typedef struct packed {
    logic [2:0] x;
    logic [2:0] y;
  } pos_t;

  // Accepted move handed to the motion controller
  typedef struct packed {
    heading_e   heading;
    logic [3:0] squares;
  } move_t;

endpackage

`default_nettype wire

//--- logic/uartRx.sv
`default_nettype none

module uartRx (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  rx,
  output logic [7:0] rxByte,
  output logic       rxValid
);

  import knightPkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rxState_e;

  rxState_e          state;
  // [0] and [1] synchronise, [2] keeps the previous synced level
  logic [2:0]        rxPipe;
  logic              rxBit;
  logic              rxPrev;
  logic [BAUD_W-1:0] baudCnt;
  logic [2:0]        bitCnt;
  logic [7:0]        shiftReg;
  logic              halfBit;
  logic              fullBit;

  assign rxBit  = rxPipe[1];
  assign rxPrev = rxPipe[2];

  // Mid-start sample point, then one full bit between samples
  assign halfBit = (baudCnt == BAUD_W'(BAUD_DIV / 2 - 1));
  assign fullBit = (baudCnt == BAUD_W'(BAUD_DIV - 1));

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    rxValid <= 1'b0;
    if (rst) begin
      rxPipe  <= '1;
      state   <= RX_IDLE;
      baudCnt <= '0;
      bitCnt  <= '0;
    end else begin
      rxPipe <= {rxPipe[1:0], rx};
      case (state)
        RX_IDLE: begin
          baudCnt <= '0;
          bitCnt  <= '0;
          // Falling edge marks the start bit
          if (rxPrev && !rxBit) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (halfBit) begin
            baudCnt <= '0;
            // Glitch shorter than half a bit goes back to idle
            state   <= rxBit ? RX_IDLE : RX_DATA;
          end else begin
            baudCnt <= baudCnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (fullBit) begin
            baudCnt <= '0;
            bitCnt  <= bitCnt + 1'b1;
            if (bitCnt == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            baudCnt <= baudCnt + 1'b1;
          end
        end
        default: begin
          if (fullBit) begin
            baudCnt <= '0;
            state   <= RX_IDLE;
            // Framing error when stop bit is low, no strobe
            rxValid <= rxBit;
          end else begin
            baudCnt <= baudCnt + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && fullBit) begin
      shiftReg <= {rxBit, shiftReg[7:1]};
    end
  end

  assign rxByte = shiftReg;

endmodule

`default_nettype wire

//--- logic/uartTx.sv
`default_nettype none

module uartTx (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       txStart,
  input  wire logic [7:0] txByte,
  output logic            tx,
  output logic            busy
);

  import knightPkg::*;

  // Stop, data and start bits, start bit goes out first
  logic [9:0]        frame;
  logic [BAUD_W-1:0] baudCnt;
  logic [3:0]        bitCnt;
  logic              bitEnd;

  assign bitEnd = (baudCnt == BAUD_W'(BAUD_DIV - 1));

  ////////////////////////////////////////
  // Bit timing
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      baudCnt <= '0;
      bitCnt  <= '0;
    end else if (txStart) begin
      busy    <= 1'b1;
      baudCnt <= '0;
      bitCnt  <= '0;
    end else if (busy) begin
      if (bitEnd) begin
        baudCnt <= '0;
        // Busy drops when the stop bit period is over
        if (bitCnt == 4'd9) begin
          busy <= 1'b0;
        end else begin
          bitCnt <= bitCnt + 1'b1;
        end
      end else begin
        baudCnt <= baudCnt + 1'b1;
      end
    end
  end

  // Frame shifter
  always_ff @(posedge clk) begin
    if (txStart) begin
      frame <= {1'b1, txByte, 1'b0};
    end else if (busy && bitEnd) begin
      frame <= {1'b1, frame[9:1]};
    end
  end

  // Line idles high
  assign tx = busy ? frame[0] : 1'b1;

  // Producer must hold off until the previous byte is out
  txNoOverlap: assert property (@(posedge clk) disable iff (rst) txStart |-> !busy)
    else $error("uartTx: txStart while busy");

endmodule

`default_nettype wire

//--- logic/cmdProc.sv
`default_nettype none

module cmdProc (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic [7:0]       rxByte,
  input  wire logic             rxValid,
  input  wire knightPkg::pos_t  pos,
  input  wire logic             moving,
  input  wire logic             moveDone,
  output knightPkg::move_t      move,
  output logic                  moveStart,
  output logic [7:0]            txByte,
  output logic                  txStart,
  input  wire logic             busy,
  output logic                  calDone
);

  import knightPkg::*;

  typedef enum logic [2:0] {
    CP_HIGH,
    CP_LOW,
    CP_DECODE,
    CP_CAL,
    CP_MOVE,
    CP_RESP,
    CP_WAIT_TX
  } cpState_e;

  cpState_e         state;
  logic [15:0]      cmdWord;
  cmd_t             cmd;
  logic [CAL_W-1:0] calCnt;
  logic [7:0]       respByte;
  logic [4:0]       reachX;
  logic [4:0]       reachY;
  logic             headingOk;
  logic             inBoard;
  logic             isCal;
  logic             moveOk;

  assign cmd = cmd_t'(cmdWord);

  ////////////////////////////////////////
  // Command checks
  ////////////////////////////////////////

  // Target coordinate for the positive directions, wide enough for 7+15
  assign reachX = 5'(pos.x) + 5'(cmd.squares);
  assign reachY = 5'(pos.y) + 5'(cmd.squares);

  always_comb begin
    headingOk = 1'b1;
    inBoard   = 1'b0;
    case (cmd.heading)
      NORTH: inBoard = (reachY <= 5'(BOARD_MAX));
      SOUTH: inBoard = (cmd.squares <= 4'(pos.y));
      EAST:  inBoard = (reachX <= 5'(BOARD_MAX));
      WEST:  inBoard = (cmd.squares <= 4'(pos.x));
      default: headingOk = 1'b0;
    endcase
  end

  // Calibration may be repeated, a move needs it done first
  assign isCal  = (cmd.opcode == CAL_GYRO);
  assign moveOk = (cmd.opcode == MOVE) && calDone && headingOk && inBoard;

  ////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    moveStart <= 1'b0;
    if (rst) begin
      state   <= CP_HIGH;
      calCnt  <= '0;
      calDone <= 1'b0;
    end else begin
      case (state)
        CP_HIGH: if (rxValid) state <= CP_LOW;
        CP_LOW:  if (rxValid) state <= CP_DECODE;
        CP_DECODE: begin
          if (isCal) begin
            calCnt <= '0;
            state  <= CP_CAL;
          end else if (!moveOk) begin
            state <= CP_RESP;
          end else if (!moving) begin
            // Launch only into an idle motion controller
            moveStart <= 1'b1;
            state     <= CP_MOVE;
          end
        end
        CP_CAL: begin
          if (calCnt == CAL_W'(CAL_CYCLES - 1)) begin
            calDone <= 1'b1;
            state   <= CP_RESP;
          end else begin
            calCnt <= calCnt + 1'b1;
          end
        end
        CP_MOVE: if (moveDone) state <= CP_RESP;
        // Response holds here while the transmitter is still busy
        CP_RESP: if (!busy) state <= CP_WAIT_TX;
        default: if (!busy) state <= CP_HIGH;
      endcase
    end
  end

  // Byte capture, high byte first
  always_ff @(posedge clk) begin
    if (rxValid && state == CP_HIGH) begin
      cmdWord[15:8] <= rxByte;
    end
    if (rxValid && state == CP_LOW) begin
      cmdWord[7:0] <= rxByte;
    end
  end

  // Response byte and move payload chosen at decode
  always_ff @(posedge clk) begin
    if (state == CP_DECODE) begin
      respByte     <= (isCal || moveOk) ? ACK : NAK;
      move.heading <= cmd.heading;
      move.squares <= cmd.squares;
    end
  end

  assign txByte  = respByte;
  assign txStart = (state == CP_RESP) && !busy;

  // No motion until the gyro has been calibrated
  moveAfterCal: assert property (@(posedge clk) disable iff (rst) moveStart |-> calDone)
    else $error("cmdProc: moveStart before calibration");

endmodule

`default_nettype wire

//--- logic/motionCtrl.sv
`default_nettype none

module motionCtrl (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire knightPkg::move_t move,
  input  wire logic             moveStart,
  output knightPkg::pos_t       pos,
  output logic                  moving,
  output logic                  moveDone
);

  import knightPkg::*;

  heading_e        heading;
  logic [3:0]      remain;
  logic [SQ_W-1:0] squareCnt;
  pos_t            nextPos;
  logic            squareEnd;

  assign squareEnd = (squareCnt == SQ_W'(SQUARE_CYCLES - 1));

  ////////////////////////////////////////
  // One square step
  ////////////////////////////////////////

  // Board limits were checked upstream
  always_comb begin
    nextPos = pos;
    case (heading)
      NORTH: nextPos.y = pos.y + 3'd1;
      SOUTH: nextPos.y = pos.y - 3'd1;
      EAST:  nextPos.x = pos.x + 3'd1;
      default: nextPos.x = pos.x - 3'd1;
    endcase
  end

  ////////////////////////////////////////
  // Move sequencing
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    moveDone <= 1'b0;
    if (rst) begin
      // Robot starts on the centre square
      pos.x     <= 3'(BOARD_MAX / 2);
      pos.y     <= 3'(BOARD_MAX / 2);
      moving    <= 1'b0;
      remain    <= '0;
      squareCnt <= '0;
    end else if (moveStart) begin
      remain    <= move.squares;
      squareCnt <= '0;
      // Zero squares finishes right away
      moving    <= (move.squares != 4'd0);
      moveDone  <= (move.squares == 4'd0);
    end else if (moving) begin
      if (squareEnd) begin
        squareCnt <= '0;
        remain    <= remain - 1'b1;
        pos       <= nextPos;
        if (remain == 4'd1) begin
          moving   <= 1'b0;
          moveDone <= 1'b1;
        end
      end else begin
        squareCnt <= squareCnt + 1'b1;
      end
    end
  end

  // Heading latched for the whole move
  always_ff @(posedge clk) begin
    if (moveStart) begin
      heading <= move.heading;
    end
  end

  // Accepted moves must keep the robot on the board
  posOnBoard: assert property (@(posedge clk) disable iff (rst)
    (pos.x <= 3'(BOARD_MAX)) && (pos.y <= 3'(BOARD_MAX)))
    else $error("motionCtrl: robot left the board");

endmodule

`default_nettype wire

//--- logic/knightTour.sv
`default_nettype none

module knightTour (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       rx,
  output logic            tx,
  output logic            calDone,
  output logic            moving,
  output knightPkg::pos_t pos
);

  import knightPkg::*;

  // Receiver to command processor
  logic [7:0] rxByte;
  logic       rxValid;

  // Command processor to motion controller
  move_t      move;
  logic       moveStart;
  logic       moveDone;

  // Command processor to transmitter
  logic [7:0] txByte;
  logic       txStart;
  logic       busy;

  ////////////////////////////////////////
  // Host link and command path
  ////////////////////////////////////////

  uartRx iRx (.clk(clk), .rst(rst), .rx(rx), .rxByte(rxByte), .rxValid(rxValid));

  cmdProc iCmd (.clk(clk), .rst(rst), .rxByte(rxByte), .rxValid(rxValid), .pos(pos),
                .moving(moving), .moveDone(moveDone), .move(move), .moveStart(moveStart),
                .txByte(txByte), .txStart(txStart), .busy(busy), .calDone(calDone));

  motionCtrl iMotion (.clk(clk), .rst(rst), .move(move), .moveStart(moveStart),
                      .pos(pos), .moving(moving), .moveDone(moveDone));

  uartTx iTx (.clk(clk), .rst(rst), .txStart(txStart), .txByte(txByte), .tx(tx),
              .busy(busy));

endmodule

`default_nettype wire

//--- dv/knightTourTb.sv
`default_nettype none

module knightTourTb;

  import knightPkg::*;

  logic clk;
  logic rst;
  logic rx;
  logic tx;
  logic calDone;
  logic moving;
  pos_t pos;

  // Scoreboard counts
  int passCount;
  int failCount;

  // Reference model of the robot
  int   refX;
  int   refY;
  logic refCal;

  logic [31:0] rngState;
  logic        movingSeen;
  logic        seenBeforeResp;

  knightTour DUT (.clk(clk), .rst(rst), .rx(rx), .tx(tx), .calDone(calDone),
                  .moving(moving), .pos(pos));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Sticky flag, cleared by the test that looks at it
  always @(negedge clk) begin
    if (moving === 1'b1) movingSeen = 1'b1;
  end

  ////////////////////////////////////////
  // Check helpers
  ////////////////////////////////////////

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) begin
      passCount++;
    end else begin
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      failCount++;
    end
  endtask

  task automatic checkTrue(input string what, input logic cond);
    assert (cond === 1'b1) begin
      passCount++;
    end else begin
      $display("Check failed at %0t: %s", $time, what);
      failCount++;
    end
  endtask

  task automatic reportTest(input string name, input int failsBefore);
    if (failCount == failsBefore) $display("test %s: ok", name);
    else $display("test %s: %0d failed checks", name, failCount - failsBefore);
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  ////////////////////////////////////////
  // UART host side
  ////////////////////////////////////////

  // 8N1 frame, LSB first
  task automatic sendByte(input logic [7:0] b);
    logic [9:0] frame;
    int i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      rx = frame[i];
      repeat (BAUD_DIV) @(negedge clk);
    end
  endtask

  // High byte goes out first
  task automatic sendCmd(input logic [15:0] word);
    sendByte(word[15:8]);
    sendByte(word[7:0]);
  endtask

  task automatic getResp(output logic [7:0] b);
    int waitCnt;
    int limit;
    int i;
    b = 'x;
    waitCnt = 0;
    // Longest case is two frames, a calibration and a long move
    limit = 40 * BAUD_DIV + CAL_CYCLES + 16 * SQUARE_CYCLES;
    while (tx !== 1'b0 && waitCnt < limit) begin
      @(negedge clk);
      waitCnt++;
    end
    if (tx !== 1'b0) begin
      checkTrue($sformatf("no start bit on tx within %0d cycles", limit), 1'b0);
      return;
    end
    seenBeforeResp = movingSeen;
    // Middle of the start bit
    repeat (BAUD_DIV / 2) @(negedge clk);
    checkTrue("start bit on tx did not stay low to mid-bit", tx === 1'b0);
    for (i = 0; i < 8; i++) begin
      repeat (BAUD_DIV) @(negedge clk);
      b[i] = tx;
    end
    repeat (BAUD_DIV) @(negedge clk);
    checkTrue("stop bit on tx was low", tx === 1'b1);
    // Let the line finish the stop bit
    repeat (BAUD_DIV / 2) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  task automatic modelCommand(input logic [15:0] word, output logic [7:0] expResp);
    logic [3:0] op;
    logic [7:0] hd;
    int         sq;
    int         newX;
    int         newY;
    logic       legal;
    op = word[15:12];
    hd = word[11:4];
    sq = word[3:0];
    newX = refX;
    newY = refY;
    legal = 1'b1;
    expResp = NAK;
    if (op == 4'h2) begin
      refCal = 1'b1;
      expResp = ACK;
    end else if (op == 4'h4 && refCal) begin
      // North is +y, east is +x
      case (hd)
        8'h00: newY = refY + sq;
        8'h3F: newX = refX - sq;
        8'h7F: newY = refY - sq;
        8'hBF: newX = refX + sq;
        default: legal = 1'b0;
      endcase
      if (legal && newX >= 0 && newX <= BOARD_MAX && newY >= 0 && newY <= BOARD_MAX) begin
        refX = newX;
        refY = newY;
        expResp = ACK;
      end
    end
  endtask

  // Send, collect the answer, compare against the model
  task automatic runCmd(input logic [15:0] word);
    logic [7:0] expResp;
    logic [7:0] gotResp;
    modelCommand(word, expResp);
    fork
      sendCmd(word);
      getResp(gotResp);
    join
    checkValue($sformatf("response to %h", word), gotResp, expResp);
    checkValue("pos.x", pos.x, refX);
    checkValue("pos.y", pos.y, refY);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic testReset();
    int failsBefore;
    failsBefore = failCount;
    checkValue("tx", tx, 1);
    checkValue("calDone", calDone, 0);
    checkValue("moving", moving, 0);
    checkValue("pos.x", pos.x, 2);
    checkValue("pos.y", pos.y, 2);
    reportTest("reset state", failsBefore);
  endtask

  task automatic testMoveBeforeCal();
    int failsBefore;
    failsBefore = failCount;
    runCmd(16'h4BF1);
    checkValue("calDone", calDone, 0);
    reportTest("move before calibration", failsBefore);
  endtask

  task automatic testCalibrate();
    int failsBefore;
    failsBefore = failCount;
    runCmd(16'h2000);
    checkValue("calDone", calDone, 1);
    reportTest("gyro calibration", failsBefore);
  endtask

  task automatic testMoveEast();
    int failsBefore;
    failsBefore = failCount;
    movingSeen = 1'b0;
    runCmd(16'h4BF1);
    checkTrue("moving was not seen high before the response", seenBeforeResp);
    checkValue("moving", moving, 0);
    reportTest("move east one square", failsBefore);
  endtask

  task automatic testRejects();
    int failsBefore;
    failsBefore = failCount;
    // Off the east edge from (3,2)
    runCmd(16'h4BF2);
    // Unknown opcode, then unknown heading
    runCmd(16'h7000);
    runCmd(16'h4121);
    reportTest("rejected commands", failsBefore);
  endtask

  task automatic testRandomMoves();
    int         failsBefore;
    int         n;
    logic [7:0] hd;
    logic [15:0] word;
    failsBefore = failCount;
    for (n = 0; n < 20; n++) begin
      rngState = xorshift(rngState);
      case (rngState[1:0])
        2'd0: hd = NORTH;
        2'd1: hd = WEST;
        2'd2: hd = SOUTH;
        default: hd = EAST;
      endcase
      // Square counts 0 to 3
      word = {4'h4, hd, 2'b00, rngState[9:8]};
      runCmd(word);
    end
    reportTest("random moves", failsBefore);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst = 1'b1;
    rx = 1'b1;
    passCount = 0;
    failCount = 0;
    refX = 2;
    refY = 2;
    refCal = 1'b0;
    rngState = 32'ha783729f;
    movingSeen = 1'b0;
    seenBeforeResp = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    testReset();
    testMoveBeforeCal();
    testCalibrate();
    testMoveEast();
    testRejects();
    testRandomMoves();
    $display("checks: %0d passed, %0d failed", passCount, failCount);
    if (failCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
logic/knightPkg.sv
logic/uartRx.sv
logic/uartTx.sv
logic/cmdProc.sv
logic/motionCtrl.sv
logic/knightTour.sv
dv/knightTourTb.sv

//--- Bender.yml
package:
  name: knight_tour

sources:
  - logic/knightPkg.sv
  - logic/uartRx.sv
  - logic/uartTx.sv
  - logic/cmdProc.sv
  - logic/motionCtrl.sv
  - logic/knightTour.sv
  - target: simulation
    files:
      - dv/knightTourTb.sv
